/* source/mc_defines.svh */
// dram scheduler geometry, request FIFO depth and timing constants
`ifndef MC_DEFINES_SVH
`define MC_DEFINES_SVH

// address geometry, banks numbered flat
`define MC_BANK_W      2   // 4 banks
`define MC_ROW_W       8
`define MC_COL_W       6
`define MC_ADDR_W      16  // {bank, row, col}

// request queue
`define MC_FIFO_DEPTH  4

// dram timing in controller cycles
`define MC_T_RCD       4   // act to rd/wr, same bank
`define MC_T_RP        4   // pre to act
`define MC_T_RAS       10  // act to pre, same bank
`define MC_T_CCD       2   // column to column, any bank
`define MC_T_REFI      300 // refresh interval
`define MC_T_RFC       12  // ref to next command

// per-bank and tccd down-counters
// must hold the largest of t_ras, t_rcd, t_rp and t_ccd
`define MC_CNT_W       4

`endif

/* source/mc_req_pkg.sv */
// host request types shared by the request FIFO and the scheduler
`include "mc_defines.svh"

package mc_req_pkg;

	// one decoded host request, as it sits in the FIFO
	typedef struct packed {
		logic                 write_en; // 1 = write, 0 = read
		logic [`MC_BANK_W-1:0] bank;
		logic [`MC_ROW_W-1:0]  row;
		logic [`MC_COL_W-1:0]  col;
	} mc_req_t;

endpackage

/* source/mc_dram_pkg.sv */
// dram command word and per-bank state types
`include "mc_defines.svh"

package mc_dram_pkg;

	typedef enum logic [2:0] {
		NOP = 3'd0,
		ACT = 3'd1, // open a row
		PRE = 3'd2, // close the bank
		RD  = 3'd3,
		WR  = 3'd4,
		REF = 3'd5  // all banks must be closed
	} mc_cmd_op_t;

	// command word on the dram side
	typedef struct packed {
		mc_cmd_op_t            op;
		logic [`MC_BANK_W-1:0] bank;
		logic [`MC_ROW_W-1:0]  row_col; // row for act, zero-extended column for rd/wr
	} mc_cmd_t;

	// scheduler view of one bank
	typedef struct packed {
		logic                 row_open;
		logic [`MC_ROW_W-1:0] open_row;
		logic [`MC_CNT_W-1:0] tras_cnt;  // cycles left before pre is allowed
		logic [`MC_CNT_W-1:0] ready_cnt; // trcd after act, trp after pre
	} mc_bank_state_t;

endpackage

/* source/mc_req_fifo.sv */
// request FIFO, wishbone classic slave that queues host requests in arrival order
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_req_fifo
	import mc_req_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  logic [`MC_ADDR_W-1:0] adr,
	output logic                  ack,
	output logic                  req_valid,
	output mc_req_t               req,
	input  logic                  req_pop
);

	localparam int PTR_W = $clog2(`MC_FIFO_DEPTH);
	localparam int CNT_W = $clog2(`MC_FIFO_DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`MC_FIFO_DEPTH - 1);
	localparam logic [CNT_W-1:0] DEPTH = CNT_W'(`MC_FIFO_DEPTH);

	mc_req_t mem [`MC_FIFO_DEPTH]; // request storage, no reset
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic full;
	mc_req_t new_req;

	assign full = (count == DEPTH);
	assign ack = cyc & stb & ~full; // low while full, master holds the cycle
	assign req_valid = (count != '0);
	assign req = mem[rd_ptr]; // head entry

	// address split, bank on top, column at the bottom
	assign new_req.write_en = we;
	assign new_req.bank = adr[`MC_ADDR_W-1 -: `MC_BANK_W];
	assign new_req.row = adr[`MC_COL_W +: `MC_ROW_W];
	assign new_req.col = adr[`MC_COL_W-1:0];

	always_ff @(posedge clk) begin
		if (ack) mem[wr_ptr] <= new_req;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (ack) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (req_pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			case ({ack, req_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // both or neither
			endcase
		end
	end

	// scheduler may only pop what is really queued
	a_pop_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
		req_pop |-> req_valid) else $error("req_pop while the request FIFO is empty");

	a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
		count <= DEPTH) else $error("request FIFO count above depth");

endmodule

/* source/mc_refresh_timer.sv */
// refresh timer, raises ref_due every trefi and holds ref_busy for trfc after ref
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_refresh_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic ref_issued,
	output logic ref_due,
	output logic ref_busy
);

	localparam int REFI_W = $clog2(`MC_T_REFI);
	localparam int RFC_W = $clog2(`MC_T_RFC + 1);

	logic [REFI_W-1:0] refi_cnt; // cycles into the current interval
	logic [RFC_W-1:0] rfc_cnt;   // trfc hold-off left

	assign ref_busy = (rfc_cnt != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			refi_cnt <= '0;
			ref_due <= 1'b0;
			rfc_cnt <= '0;
		end else begin
			if (ref_issued) begin
				refi_cnt <= REFI_W'(1); // the ref cycle itself is the first of the new interval
				ref_due <= 1'b0;
				rfc_cnt <= RFC_W'(`MC_T_RFC);
			end else begin
				if (!ref_due) begin // interval stops while waiting for ref
					if (refi_cnt == REFI_W'(`MC_T_REFI - 1)) begin
						ref_due <= 1'b1;
						refi_cnt <= '0;
					end else begin
						refi_cnt <= refi_cnt + 1'b1;
					end
				end
				if (rfc_cnt != '0) rfc_cnt <= rfc_cnt - 1'b1;
			end
		end
	end

	a_ref_when_due: assert property (@(posedge clk) disable iff (!rst_n)
		ref_issued |-> ref_due) else $error("ref issued without a pending refresh");

endmodule

/* source/mc_bank_sched.sv */
// in-order dram command scheduler, tracks open rows and bank timing, one command per cycle
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_bank_sched
	import mc_req_pkg::*;
	import mc_dram_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    req_valid,
	input  mc_req_t req,
	output logic    req_pop,
	input  logic    ref_due,
	input  logic    ref_busy,
	output logic    ref_issued,
	output logic    cmd_valid,
	output mc_cmd_t cmd
);

	localparam int NUM_BANKS = 1 << `MC_BANK_W;

	// counters load t-1 since the command itself appears one cycle after the decision
	localparam logic [`MC_CNT_W-1:0] RAS_LD = `MC_CNT_W'(`MC_T_RAS - 1);
	localparam logic [`MC_CNT_W-1:0] RCD_LD = `MC_CNT_W'(`MC_T_RCD - 1);
	localparam logic [`MC_CNT_W-1:0] RP_LD = `MC_CNT_W'(`MC_T_RP - 1);
	localparam logic [`MC_CNT_W-1:0] CCD_LD = `MC_CNT_W'(`MC_T_CCD - 1);

	mc_bank_state_t banks [NUM_BANKS];
	logic [`MC_CNT_W-1:0] ccd_cnt; // shared across banks
	mc_bank_state_t head;          // state of the bank the head request targets
	mc_cmd_t next_cmd;
	logic next_valid;

	assign head = banks[req.bank];

	// command choice
	always_comb begin
		logic found;
		logic all_idle;
		found = 1'b0;
		all_idle = 1'b1;
		next_cmd = '0; // nop
		next_valid = 1'b0;
		req_pop = 1'b0;
		ref_issued = 1'b0;
		if (ref_busy) begin
			next_valid = 1'b0; // trfc hold-off, bus stays quiet
		end else if (ref_due) begin
			// close banks lowest first, ref only when all are closed and trp is over
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (banks[i].row_open || banks[i].ready_cnt != '0) all_idle = 1'b0;
				if (!found && banks[i].row_open && banks[i].tras_cnt == '0) begin
					found = 1'b1;
					next_cmd.op = PRE;
					next_cmd.bank = `MC_BANK_W'(i);
				end
			end
			if (found) begin
				next_valid = 1'b1;
			end else if (all_idle) begin
				next_valid = 1'b1;
				next_cmd.op = REF;
				ref_issued = 1'b1;
			end
		end else if (req_valid) begin
			next_cmd.bank = req.bank;
			if (head.row_open && head.open_row != req.row) begin // row conflict
				if (head.tras_cnt == '0) begin
					next_valid = 1'b1;
					next_cmd.op = PRE;
				end
			end else if (!head.row_open) begin // closed bank
				if (head.ready_cnt == '0) begin
					next_valid = 1'b1;
					next_cmd.op = ACT;
					next_cmd.row_col = req.row;
				end
			end else if (head.ready_cnt == '0 && ccd_cnt == '0) begin // row hit
				next_valid = 1'b1;
				next_cmd.op = req.write_en ? WR : RD;
				next_cmd.row_col = `MC_ROW_W'(req.col);
				req_pop = 1'b1; // request done once its column command goes out
			end
		end
	end

	// bank state and timing counters, all saturate at zero
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_BANKS; i++) banks[i] <= '0;
			ccd_cnt <= '0;
		end else begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				if (banks[i].tras_cnt != '0) banks[i].tras_cnt <= banks[i].tras_cnt - 1'b1;
				if (banks[i].ready_cnt != '0) banks[i].ready_cnt <= banks[i].ready_cnt - 1'b1;
			end
			if (ccd_cnt != '0) ccd_cnt <= ccd_cnt - 1'b1;
			if (next_valid) begin
				case (next_cmd.op)
					ACT: begin
						banks[next_cmd.bank].row_open <= 1'b1;
						banks[next_cmd.bank].open_row <= next_cmd.row_col;
						banks[next_cmd.bank].tras_cnt <= RAS_LD;
						banks[next_cmd.bank].ready_cnt <= RCD_LD;
					end
					PRE: begin
						banks[next_cmd.bank].row_open <= 1'b0;
						banks[next_cmd.bank].ready_cnt <= RP_LD;
					end
					RD, WR:  ccd_cnt <= CCD_LD;
					default: ; // ref leaves bank state alone, all banks already closed
				endcase
			end
		end
	end

	// command register at the dram side
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) cmd_valid <= 1'b0;
		else cmd_valid <= next_valid;
	end

	always_ff @(posedge clk) begin
		cmd <= next_cmd; // only meaningful with cmd_valid
	end

	// a column command on the bus must hit a bank whose row is still open
	a_col_open_bank: assert property (@(posedge clk) disable iff (!rst_n)
		cmd_valid && (cmd.op == RD || cmd.op == WR) |-> banks[cmd.bank].row_open)
		else $error("column command to a closed bank %0d", cmd.bank);

endmodule

/* source/mc_top.sv */
// dram controller top, wishbone request FIFO feeding the refresh-aware bank scheduler
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_top
	import mc_req_pkg::*;
	import mc_dram_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cyc,
	input  logic                  stb,
	input  logic                  we,
	input  logic [`MC_ADDR_W-1:0] adr,
	output logic                  ack,
	output logic                  cmd_valid,
	output mc_cmd_t               cmd
);

	logic    req_valid;
	mc_req_t req;        // head of the request queue
	logic    req_pop;
	logic    ref_due;
	logic    ref_busy;
	logic    ref_issued;

	mc_req_fifo i_fifo (
		.clk, .rst_n, .cyc, .stb, .we, .adr, .ack,
		.req_valid, .req, .req_pop
	);

	mc_refresh_timer i_refresh (.clk, .rst_n, .ref_issued, .ref_due, .ref_busy);

	mc_bank_sched i_sched (
		.clk, .rst_n, .req_valid, .req, .req_pop,
		.ref_due, .ref_busy, .ref_issued, .cmd_valid, .cmd
	);

endmodule

/* tb/mc_cmd_checker.sv */
// command checker, keeps its own bank model and checks order, page policy and timing on the bus
`timescale 1ns/1ps
`include "mc_defines.svh"

module mc_cmd_checker
	import mc_req_pkg::*;
	import mc_dram_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    cmd_valid,
	input  mc_cmd_t cmd,
	output int      errors,
	output int      col_count,
	output int      ref_count
);

	localparam int NUM_BANKS = 1 << `MC_BANK_W;
	localparam int NEVER = -1000; // far enough back for every spacing rule

	string name_q[$]; // pending requests in acceptance order
	mc_req_t req_q[$];
	mc_cmd_t exp_q[$];

	bit open [NUM_BANKS];
	logic [`MC_ROW_W-1:0] open_row [NUM_BANKS];
	int last_act [NUM_BANKS];
	int last_pre [NUM_BANKS];
	bit snap_open [NUM_BANKS]; // bank state when the head request started
	logic [`MC_ROW_W-1:0] snap_row [NUM_BANKS];
	int acts [NUM_BANKS]; // since last column command or REF
	int pres [NUM_BANKS];
	bit ref_seen;
	int last_col;
	int last_ref;
	int cycle;

	task automatic expect_col(input string name, input mc_req_t req, input mc_cmd_t exp);
		name_q.push_back(name);
		req_q.push_back(req);
		exp_q.push_back(exp);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("[%0t] %s", $time, msg);
	endtask

	function automatic string cmd_text(input mc_cmd_t c);
		return $sformatf("%s bank %0d arg %h", c.op.name(), c.bank, c.row_col);
	endfunction

	task automatic take_snapshot();
		for (int i = 0; i < NUM_BANKS; i++) begin
			snap_open[i] = open[i];
			snap_row[i] = open_row[i];
			acts[i] = 0;
			pres[i] = 0;
		end
		ref_seen = 1'b0;
	endtask

	task automatic check_column(input mc_cmd_t c);
		string name;
		mc_req_t req;
		mc_cmd_t exp;
		int rb;
		int want_pre;
		int want_act;
		col_count++;
		if (exp_q.size() == 0) begin
			report_error($sformatf("column command %s with no request waiting", cmd_text(c)));
			return;
		end
		name = name_q.pop_front();
		req = req_q.pop_front();
		exp = exp_q.pop_front();
		rb = int'(req.bank);
		if (c !== exp) begin
			errors++;
			$display("MISMATCH %s: expected %s, actual %s", name, cmd_text(exp), cmd_text(c));
		end
		if (!open[rb] || open_row[rb] != req.row)
			report_error($sformatf("%s: row %h of bank %0d not open at its column command",
				name, req.row, rb));
		if (cycle - last_act[rb] < `MC_T_RCD)
			report_error($sformatf("%s: ACT to column only %0d cycles", name, cycle - last_act[rb]));
		if (cycle - last_col < `MC_T_CCD)
			report_error($sformatf("%s: column to column only %0d cycles", name, cycle - last_col));
		want_pre = 0;
		want_act = 1; // closed bank, also after any REF
		if (!ref_seen && snap_open[rb]) begin
			want_act = (snap_row[rb] == req.row) ? 0 : 1; // hit needs nothing
			want_pre = want_act;                            // conflict needs PRE then ACT
		end
		if (pres[rb] != want_pre || acts[rb] != want_act) begin
			errors++;
			$display("MISMATCH %s: expected %0d PRE %0d ACT, actual %0d PRE %0d ACT",
				name, want_pre, want_act, pres[rb], acts[rb]);
		end
		last_col = cycle;
		take_snapshot();
	endtask

	task automatic check_cmd(input mc_cmd_t c);
		int b;
		b = int'(c.bank);
		if (last_ref != NEVER && cycle - last_ref <= `MC_T_RFC)
			report_error($sformatf("%s issued %0d cycles after REF", cmd_text(c), cycle - last_ref));
		case (c.op)
			ACT: begin
				if (req_q.size() == 0)
					report_error($sformatf("%s with no request waiting", cmd_text(c)));
				else if (c.bank != req_q[0].bank || c.row_col != req_q[0].row) begin
					errors++;
					$display("MISMATCH %s: expected ACT bank %0d row %h, actual %s",
						name_q[0], req_q[0].bank, req_q[0].row, cmd_text(c));
				end
				if (open[b]) report_error($sformatf("ACT to bank %0d which is already open", b));
				if (cycle - last_pre[b] < `MC_T_RP)
					report_error($sformatf("PRE to ACT on bank %0d only %0d cycles", b, cycle - last_pre[b]));
				open[b] = 1'b1;
				open_row[b] = c.row_col;
				last_act[b] = cycle;
				acts[b]++;
			end
			PRE: begin
				if (!open[b]) report_error($sformatf("PRE to bank %0d which is already closed", b));
				if (cycle - last_act[b] < `MC_T_RAS)
					report_error($sformatf("ACT to PRE on bank %0d only %0d cycles", b, cycle - last_act[b]));
				open[b] = 1'b0;
				last_pre[b] = cycle;
				pres[b]++;
			end
			RD, WR: check_column(c);
			REF: begin
				for (int i = 0; i < NUM_BANKS; i++) begin
					if (open[i]) report_error($sformatf("REF while bank %0d is still open", i));
					open[i] = 1'b0; // model closes everything
					acts[i] = 0;
					pres[i] = 0;
				end
				if (ref_count > 0 && cycle - last_ref < `MC_T_REFI)
					report_error($sformatf("REF only %0d cycles after the previous one", cycle - last_ref));
				last_ref = cycle;
				ref_count++;
				ref_seen = 1'b1;
			end
			default: report_error($sformatf("unknown command op %0d on the bus", c.op));
		endcase
	endtask

	// cmd is a register, so the edge shows the command of the cycle before
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_BANKS; i++) begin
				open[i] = 1'b0;
				open_row[i] = '0;
				last_act[i] = NEVER;
				last_pre[i] = NEVER;
			end
			take_snapshot();
			errors = 0;
			col_count = 0;
			ref_count = 0;
			last_col = NEVER;
			last_ref = NEVER;
			cycle = 0;
		end else begin
			cycle++;
			if (cmd_valid) check_cmd(cmd);
		end
	end

endmodule

/* tb/tb_mc_top.sv */
// testbench top for the dram command scheduler, reads requests from a data file and drives wishbone
`timescale 1ns/1ps
`include "mc_defines.svh"

module tb_mc_top
	import mc_req_pkg::*;
	import mc_dram_pkg::*;
();

	localparam int HALF = 20; // 40 ns clock
	localparam string DATA_FILE = "tb/mc_testdata.txt";
	localparam int PER_REQ = `MC_T_RAS + `MC_T_RP + `MC_T_RCD + `MC_T_CCD + 4;
	localparam int REF_ALIGN = `MC_T_REFI - `MC_T_RAS; // burst start, still queued at the first REF

	logic clk;
	logic rst_n;
	logic cyc;
	logic stb;
	logic we;
	logic [`MC_ADDR_W-1:0] adr;
	logic ack;
	logic cmd_valid;
	mc_cmd_t cmd;
	int chk_errors;
	int col_count;
	int ref_count;
	int errors;   // file and end-of-run problems
	int cycles;
	int limit;
	string name_q[$]; // one entry per data line
	mc_req_t req_q[$];
	mc_cmd_t exp_q[$];

	mc_top i_dut (.clk, .rst_n, .cyc, .stb, .we, .adr, .ack, .cmd_valid, .cmd);

	mc_cmd_checker i_checker (
		.clk, .rst_n, .cmd_valid, .cmd,
		.errors(chk_errors), .col_count, .ref_count
	);

	always #HALF clk = ~clk;

	// run limit scales with the number of requests
	always @(posedge clk) begin
		if (rst_n) begin
			cycles++;
			if (limit > 0 && cycles > limit) begin
				$display("timeout: run not finished after %0d cycles", cycles);
				$display("%0d of %0d column commands seen, %0d refreshes",
					col_count, req_q.size(), ref_count);
				$display("** FAIL **");
				$finish;
			end
		end
	end

	task automatic read_testdata();
		int fd;
		int n;
		string name;
		string op_s;
		string exp_s;
		string rest;
		logic [`MC_BANK_W-1:0] bank;
		logic [`MC_BANK_W-1:0] exp_bank;
		logic [`MC_ROW_W-1:0] row;
		logic [`MC_COL_W-1:0] col;
		logic [`MC_COL_W-1:0] exp_col;
		mc_req_t req;
		mc_cmd_t exp;
		fd = $fopen(DATA_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the test data file %s", DATA_FILE);
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			n = $fscanf(fd, "%s", name);
			if (n != 1) break; // end of file
			if (name[0] == "#") begin
				n = $fgets(rest, fd); // comment line
				continue;
			end
			n = $fscanf(fd, "%s %h %h %h %s %h %h",
				op_s, bank, row, col, exp_s, exp_bank, exp_col);
			if (n != 7) begin
				$display("test %s has a malformed line in %s", name, DATA_FILE);
				errors++;
				break;
			end
			req.write_en = (op_s == "W");
			req.bank = bank;
			req.row = row;
			req.col = col;
			exp.op = (exp_s == "WR") ? WR : RD;
			exp.bank = exp_bank;
			exp.row_col = `MC_ROW_W'(exp_col); // column zero-extended on the bus
			name_q.push_back(name);
			req_q.push_back(req);
			exp_q.push_back(exp);
		end
		$fclose(fd);
		if (req_q.size() == 0) begin
			$display("no requests found in %s", DATA_FILE);
			errors++;
		end
	endtask

	// one wishbone write of a request starting on a falling edge
	task automatic send_request(input int idx, input bit keep_stb);
		cyc = 1'b1;
		stb = 1'b1;
		we = req_q[idx].write_en;
		adr = {req_q[idx].bank, req_q[idx].row, req_q[idx].col};
		do @(posedge clk); while (ack !== 1'b1); // ack as seen by the FIFO at this edge
		i_checker.expect_col(name_q[idx], req_q[idx], exp_q[idx]);
		@(negedge clk);
		if (!keep_stb) begin
			cyc = 1'b0;
			stb = 1'b0;
		end
	endtask

	initial begin
		int idle;
		bit burst;
		bit next_burst;
		bit prev_burst;
		clk = 1'b0;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		errors = 0;
		cycles = 0;
		limit = 0;
		prev_burst = 1'b0;
		void'($urandom(32'h25f4c496));
		read_testdata();
		limit = req_q.size() * PER_REQ
			+ ((req_q.size() * PER_REQ) / `MC_T_REFI + 1) * (4 * `MC_T_RAS + `MC_T_RFC);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		if (errors == 0) begin
			for (int i = 0; i < req_q.size(); i++) begin
				burst = (name_q[i].substr(0, 4) == "burst"); // burst lines go back to back
				next_burst = (i + 1 < req_q.size()) && (name_q[i + 1].substr(0, 4) == "burst");
				if (!burst) begin
					idle = $urandom_range(3);
					repeat (idle) @(negedge clk);
				end else if (!prev_burst) begin
					// ref_due rises MC_T_REFI cycles after reset, the burst spans it
					wait (cycles >= REF_ALIGN);
					@(negedge clk);
				end
				send_request(i, burst && next_burst);
				prev_burst = burst;
			end
			wait (col_count >= req_q.size() && ref_count > 0);
			@(negedge clk);
			if (col_count != req_q.size()) begin
				$display("saw %0d column commands for %0d requests", col_count, req_q.size());
				errors++;
			end
		end
		$display("errors %0d (checker %0d, tb %0d), columns %0d of %0d, refreshes %0d",
			chk_errors + errors, chk_errors, errors, col_count, req_q.size(), ref_count);
		if (errors == 0 && chk_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

/* tb/mc_testdata.txt */
# name  op(R/W)  bank  row  col  expected column command: op(RD/WR)  bank  col
# bank, row and column in hex; names starting with burst are sent back to back
closed_rd0      R 0 12 05  RD 0 05
hit_wr0         W 0 12 06  WR 0 06
closed_wr1      W 1 40 3f  WR 1 3f
conflict_rd0    R 0 13 00  RD 0 00
hit_rd1         R 1 40 10  RD 1 10
conflict_wr1    W 1 41 2a  WR 1 2a
closed_rd2      R 2 ff 01  RD 2 01
closed_wr3      W 3 00 3e  WR 3 3e
burst_conf_rd2  R 2 80 11  RD 2 11
burst_conf_wr3  W 3 07 12  WR 3 12
burst_hit_rd3   R 3 07 13  RD 3 13
burst_conf_wr0  W 0 aa 14  WR 0 14
burst_conf_rd1  R 1 5a 15  RD 1 15
burst_hit_wr1   W 1 5a 16  WR 1 16

/* src.f */
+incdir+source
source/mc_req_pkg.sv
source/mc_dram_pkg.sv
source/mc_req_fifo.sv
source/mc_refresh_timer.sv
source/mc_bank_sched.sv
source/mc_top.sv
tb/mc_cmd_checker.sv
tb/tb_mc_top.sv
